// ==== hdl/isa_pkg.sv ====
package isa_pkg;

  // major opcodes in bits 30:25
  localparam logic [5:0] type_basic = 6'b100000;
  localparam logic [5:0] type_ls    = 6'b011100;
  localparam logic [5:0] addi       = 6'b101000;
  localparam logic [5:0] ori        = 6'b101100;
  localparam logic [5:0] xori       = 6'b101011;
  localparam logic [5:0] lwi        = 6'b000010;
  localparam logic [5:0] swi        = 6'b001010;
  localparam logic [5:0] movi       = 6'b100010;

  // basic sub-opcodes in the low five bits of sub
  localparam logic [4:0] sub_add   = 5'b00000;
  localparam logic [4:0] sub_sub   = 5'b00001;
  localparam logic [4:0] sub_and   = 5'b00010;
  localparam logic [4:0] sub_or    = 5'b00100;
  localparam logic [4:0] sub_xor   = 5'b00011;
  localparam logic [4:0] sub_srli  = 5'b01001;
  localparam logic [4:0] sub_slli  = 5'b01000;
  localparam logic [4:0] sub_rotri = 5'b01011;

  // load/store sub-opcodes use the full sub field
  localparam logic [7:0] lw = 8'b00000010;
  localparam logic [7:0] sw = 8'b00001010;

  // register form with imm5 in rb
  typedef struct packed {
    logic       spare;
    logic [5:0] opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [1:0] sv;
    logic [7:0] sub;
  } reg_form_t;

  // immediate form where ra overlaps imm[19:15]
  typedef struct packed {
    logic        spare;
    logic [5:0]  opcode;
    logic [4:0]  rt;
    logic [19:0] imm;
  } imm_form_t;

  typedef union packed {
    reg_form_t r;
    imm_form_t i;
  } instr_t;

endpackage

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

  // sequencer states
  typedef enum logic [2:0] {
    st_stop        = 3'b000,
    st_fetch       = 3'b001,
    st_exec        = 3'b010,
    st_reg_write   = 3'b011,
    st_load_fetch  = 3'b100,
    st_load_write  = 3'b101,
    st_store_fetch = 3'b110,
    st_store_write = 3'b111
  } ctrl_state_t;

  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } imm_sel_t;

  typedef enum logic {
    alu_result = 1'b0,
    dm_out     = 1'b1
  } wb_sel_t;

  typedef enum logic {
    reg_out = 1'b0,
    imm_out = 1'b1
  } src_sel_t;

  typedef struct packed {
    logic     im_en;
    logic     im_fetch;
    logic     dm_en;
    logic     dm_fetch;
    logic     dm_write;
    logic     reg_read;
    logic     alu_execute;
    logic     reg_write;
    imm_sel_t imm_sel;
    wb_sel_t  wb_sel;
    src_sel_t src_sel;
  } ctrl_t;

endpackage

// ==== hdl/memory_block.sv ====
module memory_block #(
  parameter int mem_size  = 10,
  parameter int data_size = 32
) (
  input  logic                 clock,
  input  logic                 en,
  input  logic                 write,
  input  logic [mem_size-1:0]  addr,
  input  logic [data_size-1:0] wdata,
  output logic [data_size-1:0] rdata
);

  logic [data_size-1:0] mem [2**mem_size];

  // rdata holds its value while en is low
  always_ff @(posedge clock) begin
    if (en) begin
      if (write) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

// ==== hdl/register_file.sv ====
module register_file #(
  parameter int data_size = 32,
  parameter int addr_size = 5
) (
  input  logic                 clock,
  input  logic                 reset,
  input  ctrl_pkg::ctrl_t      ctrl,
  input  logic [addr_size-1:0] ra_addr,
  input  logic [addr_size-1:0] rb_addr,
  input  logic [addr_size-1:0] wr_addr,
  input  logic [data_size-1:0] wr_data,
  output logic [data_size-1:0] ra_data,
  output logic [data_size-1:0] rb_data
);

  logic [data_size-1:0] regs [2**addr_size];

  // r0 is never written
  always_ff @(posedge clock) begin
    if (ctrl.reg_write && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ra_data <= '0;
      rb_data <= '0;
    end else if (ctrl.reg_read) begin
      ra_data <= (ra_addr == '0) ? '0 : regs[ra_addr];
      rb_data <= (rb_addr == '0) ? '0 : regs[rb_addr];
    end
  end

endmodule

// ==== hdl/operand_alu.sv ====
module operand_alu #(
  parameter int data_size = 32
) (
  input  logic                 clock,
  input  logic                 reset,
  input  ctrl_pkg::ctrl_t      ctrl,
  input  isa_pkg::instr_t      instr,
  input  logic [data_size-1:0] ra_data,
  input  logic [data_size-1:0] rb_data,
  output logic [data_size-1:0] result
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  localparam int sh_w = $clog2(data_size);

  logic [data_size-1:0]   imm;
  logic [data_size-1:0]   opnd_b;
  logic [data_size-1:0]   alu_out;
  logic [2*data_size-1:0] rot;
  logic [sh_w-1:0]        sh;

  // immediate extension
  always_comb begin
    case (ctrl.imm_sel)
      imm5_ze:  imm = {{(data_size-5){1'b0}}, instr.r.rb};
      imm15_se: imm = {{(data_size-15){instr.i.imm[14]}}, instr.i.imm[14:0]};
      imm15_ze: imm = {{(data_size-15){1'b0}}, instr.i.imm[14:0]};
      default:  imm = {{(data_size-20){instr.i.imm[19]}}, instr.i.imm};
    endcase
  end

  assign opnd_b = (ctrl.src_sel == imm_out) ? imm : rb_data;
  assign sh     = opnd_b[sh_w-1:0];
  assign rot    = {ra_data, ra_data} >> sh;

  // address generation for loads and stores falls to the add
  always_comb begin
    alu_out = ra_data + opnd_b;
    case (instr.r.opcode)
      type_basic: begin
        case (instr.r.sub[4:0])
          sub_sub:   alu_out = ra_data - opnd_b;
          sub_and:   alu_out = ra_data & opnd_b;
          sub_or:    alu_out = ra_data | opnd_b;
          sub_xor:   alu_out = ra_data ^ opnd_b;
          sub_srli:  alu_out = ra_data >> sh;
          sub_slli:  alu_out = ra_data << sh;
          sub_rotri: alu_out = rot[data_size-1:0];
          default:   alu_out = ra_data + opnd_b;
        endcase
      end
      ori:     alu_out = ra_data | opnd_b;
      xori:    alu_out = ra_data ^ opnd_b;
      movi:    alu_out = opnd_b;
      default: alu_out = ra_data + opnd_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (ctrl.alu_execute) begin
      result <= alu_out;
    end
  end

endmodule

// ==== hdl/ir_controller.sv ====
module ir_controller #(
  parameter int mem_size  = 10,
  parameter int data_size = 32,
  parameter int addr_size = 5
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 run,
  input  logic [data_size-1:0] ir,
  output logic [mem_size-1:0]  pc,
  output ctrl_pkg::ctrl_t      ctrl,
  output isa_pkg::instr_t      instr,
  output logic                 retire
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  ctrl_state_t          state;
  ctrl_state_t          state_next;
  instr_t               instr_reg;
  logic [4:0]           sub5;
  logic [addr_size-1:0] shamt;
  logic                 is_load;
  logic                 is_store;
  logic                 is_shift;
  logic                 is_nop;
  logic                 writes_reg;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_stop;
    end else begin
      state <= state_next;
    end
  end

  // every instruction walks all eight states
  always_comb begin
    case (state)
      st_stop:        state_next = run ? st_fetch : st_stop;
      st_fetch:       state_next = st_exec;
      st_exec:        state_next = st_load_fetch;
      st_load_fetch:  state_next = st_load_write;
      st_load_write:  state_next = st_reg_write;
      st_reg_write:   state_next = st_store_fetch;
      st_store_fetch: state_next = st_store_write;
      default:        state_next = st_stop;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (state == st_stop && !run) begin
      // program restarts from word 0
      pc <= '0;
    end else if (state == st_store_write) begin
      pc <= pc + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_exec) begin
      instr_reg <= ir;
    end
  end

  // imem output already holds the word during fetch and execute
  assign instr = (state == st_fetch || state == st_exec) ? instr_t'(ir) : instr_reg;

  assign sub5  = instr.r.sub[4:0];
  assign shamt = instr.r.rb;

  assign is_load  = instr.r.opcode == lwi || (instr.r.opcode == type_ls && instr.r.sub == lw);
  assign is_store = instr.r.opcode == swi || (instr.r.opcode == type_ls && instr.r.sub == sw);
  assign is_shift = instr.r.opcode == type_basic &&
                    (sub5 == sub_srli || sub5 == sub_slli || sub5 == sub_rotri);
  // srli by zero
  assign is_nop   = instr.r.opcode == type_basic && sub5 == sub_srli && shamt == '0;

  always_comb begin
    case (instr.r.opcode)
      type_basic:             writes_reg = !is_nop;
      addi, ori, xori, movi:  writes_reg = 1'b1;
      lwi:                    writes_reg = 1'b1;
      type_ls:                writes_reg = instr.r.sub == lw;
      default:                writes_reg = 1'b0;
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (state)
      st_stop: begin
        if (run) begin
          ctrl.im_en    = 1'b1;
          ctrl.im_fetch = 1'b1;
        end
      end
      st_fetch: begin
        ctrl.im_en    = 1'b1;
        ctrl.im_fetch = 1'b1;
        ctrl.reg_read = 1'b1;
      end
      st_exec: begin
        ctrl.alu_execute = 1'b1;
      end
      st_load_fetch: begin
        ctrl.dm_en    = is_load;
        ctrl.dm_fetch = is_load;
      end
      st_reg_write: begin
        ctrl.reg_write = writes_reg;
      end
      st_store_fetch: begin
        // second read for the store data in rt
        ctrl.reg_read = is_store;
      end
      st_store_write: begin
        ctrl.dm_en    = is_store;
        ctrl.dm_write = is_store;
      end
      default: begin
        // data memory output settles in load write
      end
    endcase

    ctrl.wb_sel = is_load ? dm_out : alu_result;

    case (instr.r.opcode)
      type_basic: begin
        ctrl.imm_sel = imm5_ze;
        ctrl.src_sel = is_shift ? imm_out : reg_out;
      end
      addi: begin
        ctrl.imm_sel = imm15_se;
        ctrl.src_sel = imm_out;
      end
      ori, xori, lwi, swi: begin
        ctrl.imm_sel = imm15_ze;
        ctrl.src_sel = imm_out;
      end
      movi: begin
        ctrl.imm_sel = imm20_se;
        ctrl.src_sel = imm_out;
      end
      default: begin
        ctrl.imm_sel = imm5_ze;
        ctrl.src_sel = reg_out;
      end
    endcase
  end

  assign retire = state == st_store_write;

endmodule

// ==== hdl/core_top.sv ====
module core_top #(
  parameter int mem_size  = 10,
  parameter int data_size = 32,
  parameter int addr_size = 5
) (
  clock,
  reset,
  run,
  prog,
  retire,
  store
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  // program-write and store bus
  typedef struct packed {
    logic                 valid;
    logic [mem_size-1:0]  addr;
    logic [data_size-1:0] data;
  } mem_load_t;

  input  logic      clock;
  input  logic      reset;
  input  logic      run;
  input  mem_load_t prog;
  output logic      retire;
  output mem_load_t store;

  logic [mem_size-1:0]  pc;
  ctrl_t                ctrl;
  instr_t               instr;
  logic [data_size-1:0] im_rdata;
  logic [data_size-1:0] dm_rdata;
  logic [data_size-1:0] ra_data;
  logic [data_size-1:0] rb_data;
  logic [data_size-1:0] result;
  logic [data_size-1:0] wr_data;
  logic [addr_size-1:0] rb_addr;
  logic [mem_size-1:0]  im_addr;
  logic [mem_size-1:0]  dm_addr;
  logic                 im_en;
  logic                 im_write;
  logic                 dm_en;

  // program bus owns the imem port while stopped
  assign im_en    = run ? (ctrl.im_en & ctrl.im_fetch) : prog.valid;
  assign im_write = ~run & prog.valid;
  assign im_addr  = run ? pc : prog.addr;

  // outside fetch the second port reads rt for the store data
  assign rb_addr = ctrl.im_fetch ? instr.r.rb : instr.r.rt;

  assign wr_data = (ctrl.wb_sel == dm_out) ? dm_rdata : result;
  assign dm_addr = result[mem_size-1:0];
  assign dm_en   = ctrl.dm_en & (ctrl.dm_fetch | ctrl.dm_write);

  assign store = {ctrl.dm_write, dm_addr, rb_data};

  ir_controller #(
    .mem_size (mem_size),
    .data_size(data_size),
    .addr_size(addr_size)
  ) u_ir_controller (
    .clock (clock),
    .reset (reset),
    .run   (run),
    .ir    (im_rdata),
    .pc    (pc),
    .ctrl  (ctrl),
    .instr (instr),
    .retire(retire)
  );

  register_file #(
    .data_size(data_size),
    .addr_size(addr_size)
  ) u_register_file (
    .clock  (clock),
    .reset  (reset),
    .ctrl   (ctrl),
    .ra_addr(instr.r.ra),
    .rb_addr(rb_addr),
    .wr_addr(instr.r.rt),
    .wr_data(wr_data),
    .ra_data(ra_data),
    .rb_data(rb_data)
  );

  operand_alu #(
    .data_size(data_size)
  ) u_operand_alu (
    .clock  (clock),
    .reset  (reset),
    .ctrl   (ctrl),
    .instr  (instr),
    .ra_data(ra_data),
    .rb_data(rb_data),
    .result (result)
  );

  memory_block #(
    .mem_size (mem_size),
    .data_size(data_size)
  ) u_imem (
    .clock(clock),
    .en   (im_en),
    .write(im_write),
    .addr (im_addr),
    .wdata(prog.data),
    .rdata(im_rdata)
  );

  memory_block #(
    .mem_size (mem_size),
    .data_size(data_size)
  ) u_dmem (
    .clock(clock),
    .en   (dm_en),
    .write(ctrl.dm_write),
    .addr (dm_addr),
    .wdata(rb_data),
    .rdata(dm_rdata)
  );

endmodule

// ==== verification/core_assertions.sv ====
module core_assertions #(
  parameter int mem_size = 10
) (
  input logic                clock,
  input logic                reset,
  input ctrl_pkg::ctrl_t     ctrl,
  input logic                retire,
  input logic [mem_size-1:0] pc
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] strobes;

  assign strobes = {ctrl.im_en, ctrl.im_fetch, ctrl.dm_en, ctrl.dm_fetch,
                    ctrl.dm_write, ctrl.reg_read, ctrl.alu_execute, ctrl.reg_write};

  no_store_on_write: assert property (@(posedge clock) disable iff (reset)
    !(ctrl.dm_write && ctrl.reg_write))
    else $error("dm_write and reg_write asserted in the same cycle");

  retire_single: assert property (@(posedge clock) disable iff (reset) retire |=> !retire)
    else $error("retire held for more than one cycle");

  // controller idle in the cycle after reset
  idle_after_reset: assert property (@(posedge clock)
    reset |=> (strobes == '0 && !retire && pc == '0))
    else $error("strobes, retire or pc not cleared by reset");

endmodule

bind ir_controller core_assertions #(.mem_size(mem_size)) u_core_assertions (
  .clock (clock),
  .reset (reset),
  .ctrl  (ctrl),
  .retire(retire),
  .pc    (pc)
);

// ==== verification/core_tb.sv ====
module core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import isa_pkg::*;

  localparam int mem_size       = 10;
  localparam int n_rows         = 20;
  localparam int timeout_cycles = 200;

  typedef struct packed {
    logic                valid;
    logic [mem_size-1:0] addr;
    logic [31:0]         data;
  } bus_t;

  typedef enum {
    k_add, k_sub, k_and, k_or, k_xor, k_slli, k_srli, k_rotri,
    k_addi, k_ori, k_xori, k_movi, k_nop, k_lwi, k_lw, k_r0
  } kind_t;

  typedef struct {
    kind_t       kind;
    logic [19:0] a;
    logic [19:0] b;
    logic [19:0] imm;
    logic [31:0] expected;
  } row_t;

  logic clock = 1'b0;
  logic reset;
  logic run;
  bus_t prog;
  logic retire;
  bus_t store;

  row_t                rows [n_rows];
  logic [31:0]         words [$];
  logic [mem_size-1:0] exp_addr [$];
  logic [31:0]         exp_data [$];
  logic [31:0]         lcg_state = 32'h5fd9_c2a0;
  int                  error_count = 0;
  int                  check_count = 0;
  bit                  timed_out = 1'b0;

  core_top #(.mem_size(mem_size)) u_core_top (
    .clock (clock),
    .reset (reset),
    .run   (run),
    .prog  (prog),
    .retire(retire),
    .store (store)
  );

  always #20 clock = ~clock;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] reg_word(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
                                           logic [4:0] rb, logic [7:0] sub);
    return {1'b0, op, rt, ra, rb, 2'b00, sub};
  endfunction

  function automatic logic [31:0] imm15_word(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
                                             logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  function automatic logic [31:0] imm20_word(logic [5:0] op, logic [4:0] rt, logic [19:0] imm);
    return {1'b0, op, rt, imm};
  endfunction

  function automatic logic [31:0] sext20(logic [19:0] v);
    return {{12{v[19]}}, v};
  endfunction

  // value the final store should carry
  function automatic logic [31:0] model_result(row_t r);
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] res;
    int          sh;
    va = sext20(r.a);
    vb = sext20(r.b);
    sh = int'(r.imm[4:0]);
    case (r.kind)
      k_add, k_nop: res = va + vb;
      k_sub:        res = va - vb;
      k_and:        res = va & vb;
      k_or:         res = va | vb;
      k_xor:        res = va ^ vb;
      k_slli:       res = va << sh;
      k_srli:       res = va >> sh;
      k_rotri:      res = (va >> sh) | (va << (32 - sh));
      k_addi:       res = va + {{17{r.imm[14]}}, r.imm[14:0]};
      k_ori:        res = va | {17'b0, r.imm[14:0]};
      k_xori:       res = va ^ {17'b0, r.imm[14:0]};
      k_movi:       res = sext20(r.imm);
      k_lwi, k_lw:  res = va;
      default:      res = 32'h0;
    endcase
    return res;
  endfunction

  task automatic fill_table();
    kind_t       kinds [n_rows];
    bit          negs [n_rows];
    logic [31:0] rnd;
    kinds = '{k_add, k_sub, k_and, k_or, k_xor, k_slli, k_srli, k_rotri, k_addi, k_addi,
              k_ori, k_xori, k_movi, k_movi, k_nop, k_lwi, k_lw, k_r0, k_rotri, k_sub};
    negs  = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 0, 1, 0, 0, 0, 0, 0, 0};
    for (int i = 0; i < n_rows; i++) begin
      rows[i].kind = kinds[i];
      rnd = lcg_next();
      rows[i].a = rnd[31:12];
      rnd = lcg_next();
      rows[i].b = rnd[31:12];
      rnd = lcg_next();
      rows[i].imm = rnd[31:12];
      // top bit of imm15 and imm20
      if (negs[i]) begin
        rows[i].imm[19] = 1'b1;
        rows[i].imm[14] = 1'b1;
      end
      // zero shift would be a nop
      if (rows[i].imm[4:0] == 5'd0) begin
        rows[i].imm[0] = 1'b1;
      end
      rows[i].expected = model_result(rows[i]);
    end
  endtask

  task automatic build_program(int idx);
    row_t                r;
    logic [mem_size-1:0] addr_a;
    logic [mem_size-1:0] addr_b;
    r = rows[idx];
    addr_a = mem_size'(16 + 2 * idx);
    addr_b = mem_size'(17 + 2 * idx);
    words.delete();
    exp_addr.delete();
    exp_data.delete();
    words.push_back(imm20_word(movi, 5'd1, r.a));
    // lw takes its address from r2
    if (r.kind == k_lw) begin
      words.push_back(imm20_word(movi, 5'd2, 20'(addr_a)));
    end else begin
      words.push_back(imm20_word(movi, 5'd2, r.b));
    end
    case (r.kind)
      k_add:   words.push_back(reg_word(type_basic, 5'd3, 5'd1, 5'd2, {3'b0, sub_add}));
      k_sub:   words.push_back(reg_word(type_basic, 5'd3, 5'd1, 5'd2, {3'b0, sub_sub}));
      k_and:   words.push_back(reg_word(type_basic, 5'd3, 5'd1, 5'd2, {3'b0, sub_and}));
      k_or:    words.push_back(reg_word(type_basic, 5'd3, 5'd1, 5'd2, {3'b0, sub_or}));
      k_xor:   words.push_back(reg_word(type_basic, 5'd3, 5'd1, 5'd2, {3'b0, sub_xor}));
      k_slli:  words.push_back(reg_word(type_basic, 5'd3, 5'd1, r.imm[4:0], {3'b0, sub_slli}));
      k_srli:  words.push_back(reg_word(type_basic, 5'd3, 5'd1, r.imm[4:0], {3'b0, sub_srli}));
      k_rotri: words.push_back(reg_word(type_basic, 5'd3, 5'd1, r.imm[4:0], {3'b0, sub_rotri}));
      k_addi:  words.push_back(imm15_word(addi, 5'd3, 5'd1, r.imm[14:0]));
      k_ori:   words.push_back(imm15_word(ori, 5'd3, 5'd1, r.imm[14:0]));
      k_xori:  words.push_back(imm15_word(xori, 5'd3, 5'd1, r.imm[14:0]));
      k_movi:  words.push_back(imm20_word(movi, 5'd3, r.imm));
      k_r0:    words.push_back(reg_word(type_basic, 5'd0, 5'd1, 5'd2, {3'b0, sub_add}));
      k_nop: begin
        words.push_back(reg_word(type_basic, 5'd3, 5'd1, 5'd2, {3'b0, sub_add}));
        // srli r3 by zero would leave r1 in r3 if it wrote
        words.push_back(reg_word(type_basic, 5'd3, 5'd1, 5'd0, {3'b0, sub_srli}));
      end
      k_lwi: begin
        words.push_back(imm15_word(swi, 5'd1, 5'd0, 15'(addr_a)));
        words.push_back(imm15_word(lwi, 5'd4, 5'd0, 15'(addr_a)));
      end
      default: begin
        words.push_back(imm15_word(swi, 5'd1, 5'd0, 15'(addr_a)));
        words.push_back(reg_word(type_ls, 5'd4, 5'd0, 5'd2, lw));
      end
    endcase
    if (r.kind == k_lwi || r.kind == k_lw) begin
      words.push_back(imm15_word(swi, 5'd4, 5'd0, 15'(addr_b)));
      exp_addr.push_back(addr_a);
      exp_data.push_back(r.expected);
      exp_addr.push_back(addr_b);
      exp_data.push_back(r.expected);
    end else begin
      words.push_back(imm15_word(swi, (r.kind == k_r0) ? 5'd0 : 5'd3, 5'd0, 15'(addr_a)));
      exp_addr.push_back(addr_a);
      exp_data.push_back(r.expected);
    end
  endtask

  task automatic check_value(string name, int idx, logic [31:0] got, logic [31:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[FAIL] row %0d %s: got %h, expected %h", idx, name, got, want);
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < words.size(); i++) begin
      @(posedge clock);
      #2;
      prog = '{valid: 1'b1, addr: mem_size'(i), data: words[i]};
    end
    @(posedge clock);
    #2;
    prog = '0;
  endtask

  task automatic run_program(int idx);
    int cycles;
    int n;
    int retire_count;
    cycles = 0;
    n = 0;
    retire_count = 0;
    @(posedge clock);
    #2;
    run = 1'b1;
    while (n < exp_data.size() && cycles < timeout_cycles) begin
      @(negedge clock);
      cycles++;
      if (retire) begin
        retire_count++;
      end
      if (store.valid) begin
        check_value("store.addr", idx, 32'(store.addr), 32'(exp_addr[n]));
        check_value("store.data", idx, store.data, exp_data[n]);
        n++;
      end
    end
    if (n < exp_data.size()) begin
      error_count++;
      timed_out = 1'b1;
      $display("row %0d timed out after %0d cycles with %0d of %0d stores seen",
               idx, cycles, n, exp_data.size());
    end
    @(posedge clock);
    #2;
    run = 1'b0;
    if (!timed_out) begin
      check_value("retire count", idx, 32'(retire_count), 32'(words.size()));
    end
  endtask

  initial begin
    reset = 1'b1;
    run = 1'b0;
    prog = '0;
    fill_table();
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      build_program(i);
      load_program();
      run_program(i);
      if (timed_out) begin
        break;
      end
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/memory_block.sv
hdl/register_file.sv
hdl/operand_alu.sv
hdl/ir_controller.sv
hdl/core_top.sv
verification/core_assertions.sv
verification/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module core_tb -f sim.f -o core_sim

./obj_dir/core_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
